// ==== hw/cache_pkg.sv ====
package cache_pkg;

    // Refill sequencer state
    typedef enum logic [2:0] {
        NORMAL,
        IC_MISS,
        DC_MISS,
        DOUBLE_MISS,
        DC_WRITEBACK
    } cache_state_t;

    // RAM address sources
    localparam logic [1:0] RAM_SEL_IC = 2'd0;
    localparam logic [1:0] RAM_SEL_DC = 2'd1;
    localparam logic [1:0] RAM_SEL_WB = 2'd2;

    // Data access from the processor, word addressed
    typedef struct packed {
        logic        read;
        logic        write;
        logic [3:0]  byte_en;
        logic [29:0] addr;
        logic [31:0] wdata;
    } dc_req_t;

    typedef struct packed {
        logic        en;
        logic        write;
        logic [29:0] addr;
        logic [31:0] wdata;
    } ram_req_t;

    // ready is a one cycle strobe per word
    typedef struct packed {
        logic        ready;
        logic [31:0] rdata;
    } ram_rsp_t;

    // Command to one cache
    // A clear cmp selects a direct fill into the victim way
    typedef struct packed {
        logic       enable;
        logic       cmp;
        logic       write;
        logic [3:0] byte_en;
        logic       valid;
    } cache_cmd_t;

endpackage

// ==== hw/cache_2ways.sv ====
`timescale 1ns/1ps

module cache_2ways
    import cache_pkg::*;
#(
    parameter int OFFSET_WIDTH = 3,
    parameter int INDEX_WIDTH  = 6,
    localparam int TAG_WIDTH   = 30 - OFFSET_WIDTH - INDEX_WIDTH
) (
    input  logic                    clk,
    input  logic                    rst,
    input  cache_cmd_t              cmd,
    input  logic [TAG_WIDTH-1:0]    tag_in,
    input  logic [INDEX_WIDTH-1:0]  index,
    input  logic [OFFSET_WIDTH-1:0] word_sel,
    input  logic [31:0]             data_in,
    output logic                    hit,
    output logic                    dirty,
    output logic                    valid_out,
    output logic [TAG_WIDTH-1:0]    tag_out,
    output logic [31:0]             data_out
);

    localparam int SETS  = 1 << INDEX_WIDTH;
    localparam int WORDS = 1 << OFFSET_WIDTH;

    ////////////////////////////////////////////////////////////////////////////
    // Storage
    ////////////////////////////////////////////////////////////////////////////

    logic [TAG_WIDTH-1:0] tag_mem  [2][SETS];
    logic [31:0]          data_mem [2][SETS][WORDS];

    logic [SETS-1:0] valid_q [2];
    logic [SETS-1:0] dirty_q [2];
    // Points at the way to evict next
    logic [SETS-1:0] lru_q;

    logic [1:0] match;
    logic       victim;
    logic       way;
    logic       do_write;

    ////////////////////////////////////////////////////////////////////////////
    // Lookup
    ////////////////////////////////////////////////////////////////////////////

    assign match[0] = valid_q[0][index] && (tag_mem[0][index] == tag_in);
    assign match[1] = valid_q[1][index] && (tag_mem[1][index] == tag_in);

    assign victim = lru_q[index];
    assign hit    = cmd.enable && cmd.cmp && (|match);

    // Matching way on a hit, otherwise the victim
    assign way = hit ? match[1] : victim;

    assign valid_out = valid_q[way][index];
    assign dirty     = dirty_q[way][index];
    assign tag_out   = tag_mem[way][index];
    assign data_out  = data_mem[way][index][word_sel];

    // Store hit, or a fill word into the victim
    assign do_write = cmd.enable && cmd.write && (hit || !cmd.cmp);

    ////////////////////////////////////////////////////////////////////////////
    // Update
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '{default: '0};
            dirty_q <= '{default: '0};
            lru_q   <= '0;
        end else if (do_write) begin
            if (hit) begin
                dirty_q[way][index] <= 1'b1;
                lru_q[index]        <= ~way;
            end else begin
                // Block stays invalid until its last word is in
                valid_q[way][index] <= cmd.valid;
                dirty_q[way][index] <= 1'b0;
                if (cmd.valid) begin
                    lru_q[index] <= ~way;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_write) begin
            for (int b = 0; b < 4; b++) begin
                if (cmd.byte_en[b]) begin
                    data_mem[way][index][word_sel][8*b +: 8] <= data_in[8*b +: 8];
                end
            end
            if (!cmd.cmp) begin
                tag_mem[way][index] <= tag_in;
            end
        end
    end

endmodule

// ==== hw/cache_control.sv ====
`timescale 1ns/1ps

module cache_control
    import cache_pkg::*;
#(
    parameter int OFFSET_WIDTH = 3
) (
    input  dc_req_t                 dc_req,
    input  logic [OFFSET_WIDTH-1:0] ic_offset,
    input  logic [OFFSET_WIDTH-1:0] dc_offset,
    input  logic                    ic_hit,
    input  logic                    ic_valid,
    input  logic                    dc_hit,
    input  logic                    dc_dirty,
    input  logic                    dc_valid,
    input  logic [31:0]             dc_wb_word,
    input  cache_state_t            state,
    input  logic [OFFSET_WIDTH-1:0] counter,
    input  logic                    ram_ready,
    output cache_cmd_t              ic_cmd,
    output cache_cmd_t              dc_cmd,
    output logic [OFFSET_WIDTH-1:0] ic_word_sel,
    output logic [OFFSET_WIDTH-1:0] dc_word_sel,
    output logic [1:0]              ram_addr_sel,
    output ram_req_t                ram_req,
    output cache_state_t            state_next,
    output logic [OFFSET_WIDTH-1:0] counter_next
);

    logic last_word;
    logic dc_access;
    logic ic_miss;
    logic dc_miss;
    logic copy_from_dc;

    assign last_word = &counter;
    assign dc_access = dc_req.read || dc_req.write;
    assign ic_miss   = !(ic_hit && ic_valid);
    assign dc_miss   = dc_access && !dc_hit;

    // During an instruction load the data cache is probed at the fetch address
    assign copy_from_dc = dc_hit && dc_valid;

    always_comb begin
        // Both caches compare at the processor addresses
        ic_cmd = '{enable: 1'b1, cmp: 1'b1, write: 1'b0, byte_en: 4'h0, valid: 1'b0};
        dc_cmd = '{enable: dc_access, cmp: 1'b1, write: dc_req.write,
                   byte_en: dc_req.byte_en, valid: 1'b0};
        ic_word_sel  = ic_offset;
        dc_word_sel  = dc_offset;
        ram_addr_sel = RAM_SEL_IC;
        // Address field is formed in the top level
        ram_req      = '0;
        state_next   = state;
        // Only taken when the top level advances
        counter_next = counter + 1'b1;

        case (state)
            NORMAL: begin
                counter_next = '0;
                if (dc_miss && dc_valid && dc_dirty) begin
                    state_next = DC_WRITEBACK;
                end else if (ic_miss && dc_miss) begin
                    state_next = DOUBLE_MISS;
                end else if (ic_miss) begin
                    state_next = IC_MISS;
                end else if (dc_miss) begin
                    state_next = DC_MISS;
                end
            end

            DC_WRITEBACK: begin
                // Read the victim word by word
                dc_cmd = '{enable: 1'b1, cmp: 1'b0, write: 1'b0, byte_en: 4'h0, valid: 1'b0};
                dc_word_sel   = counter;
                ram_addr_sel  = RAM_SEL_WB;
                ram_req.en    = 1'b1;
                ram_req.write = 1'b1;
                ram_req.wdata = dc_wb_word;
                if (last_word) begin
                    state_next = DC_MISS;
                end
            end

            DC_MISS: begin
                dc_cmd = '{enable: 1'b1, cmp: 1'b0, write: ram_ready,
                           byte_en: 4'hf, valid: last_word};
                dc_word_sel  = counter;
                ram_addr_sel = RAM_SEL_DC;
                ram_req.en   = 1'b1;
                if (last_word) begin
                    state_next = NORMAL;
                end
            end

            IC_MISS, DOUBLE_MISS: begin
                dc_cmd = '{enable: 1'b1, cmp: 1'b1, write: 1'b0, byte_en: 4'h0, valid: 1'b0};
                dc_word_sel = counter;
                ic_cmd = '{enable: 1'b1, cmp: 1'b0, write: copy_from_dc || ram_ready,
                           byte_en: 4'hf, valid: last_word};
                ic_word_sel  = counter;
                ram_addr_sel = RAM_SEL_IC;
                // RAM stays idle when the block comes from the data cache
                ram_req.en   = !copy_from_dc;
                if (last_word) begin
                    // dc victim was clean when the double miss was seen
                    state_next = (state == DOUBLE_MISS) ? DC_MISS : NORMAL;
                end
            end

            default: begin
                state_next = NORMAL;
            end
        endcase
    end

endmodule

// ==== hw/cache_manage_unit.sv ====
`timescale 1ns/1ps

module cache_manage_unit
    import cache_pkg::*;
#(
    parameter int OFFSET_WIDTH = 3,
    parameter int INDEX_WIDTH  = 6
) (
    input  logic        clk,
    input  logic        rst,
    input  logic [29:0] ic_addr,
    input  dc_req_t     dc_req,
    output logic [31:0] ic_data,
    output logic [31:0] dc_data,
    output logic        mem_stall,
    output ram_req_t    ram_req,
    input  ram_rsp_t    ram_rsp
);

    localparam int TAG_WIDTH = 30 - OFFSET_WIDTH - INDEX_WIDTH;

    cache_state_t            state;
    cache_state_t            state_next;
    logic [OFFSET_WIDTH-1:0] counter;
    logic [OFFSET_WIDTH-1:0] counter_next;

    logic [TAG_WIDTH-1:0]    ic_tag;
    logic [TAG_WIDTH-1:0]    dc_tag;
    logic [TAG_WIDTH-1:0]    dc_tag_out;
    logic [INDEX_WIDTH-1:0]  ic_index;
    logic [INDEX_WIDTH-1:0]  dc_index;
    logic [OFFSET_WIDTH-1:0] ic_offset;
    logic [OFFSET_WIDTH-1:0] dc_offset;
    logic [OFFSET_WIDTH-1:0] ic_word_sel;
    logic [OFFSET_WIDTH-1:0] dc_word_sel;

    cache_cmd_t  ic_cmd;
    cache_cmd_t  dc_cmd;
    logic        ic_hit;
    logic        ic_valid;
    logic        dc_hit;
    logic        dc_dirty;
    logic        dc_valid;
    logic [31:0] ic_data_in;
    logic [31:0] dc_data_in;
    logic [1:0]  ram_addr_sel;
    logic [29:0] ram_addr;
    ram_req_t    ctrl_ram_req;

    logic loading_ic;
    logic dc_copy;
    logic advance;

    ////////////////////////////////////////////////////////////////////////////
    // Address split and steering
    ////////////////////////////////////////////////////////////////////////////

    assign loading_ic = (state == IC_MISS) || (state == DOUBLE_MISS);

    assign ic_tag    = ic_addr[29 -: TAG_WIDTH];
    assign ic_index  = ic_addr[OFFSET_WIDTH +: INDEX_WIDTH];
    assign ic_offset = ic_addr[OFFSET_WIDTH-1:0];
    assign dc_offset = dc_req.addr[OFFSET_WIDTH-1:0];

    // Data cache looks at the fetch block while the instruction cache loads
    assign dc_tag   = loading_ic ? ic_tag   : dc_req.addr[29 -: TAG_WIDTH];
    assign dc_index = loading_ic ? ic_index : dc_req.addr[OFFSET_WIDTH +: INDEX_WIDTH];

    assign dc_copy    = loading_ic && dc_hit;
    assign ic_data_in = dc_copy ? dc_data : ram_rsp.rdata;
    assign dc_data_in = (state == NORMAL) ? dc_req.wdata : ram_rsp.rdata;

    always_comb begin
        case (ram_addr_sel)
            RAM_SEL_DC: ram_addr = {dc_req.addr[29:OFFSET_WIDTH], counter};
            RAM_SEL_WB: ram_addr = {dc_tag_out, dc_index, counter};
            default:    ram_addr = {ic_tag, ic_index, counter};
        endcase
    end

    assign ram_req = '{en: ctrl_ram_req.en, write: ctrl_ram_req.write,
                       addr: ram_addr, wdata: ctrl_ram_req.wdata};

    ////////////////////////////////////////////////////////////////////////////
    // Sequencer registers
    ////////////////////////////////////////////////////////////////////////////

    assign advance = (state == NORMAL) || ram_rsp.ready || dc_copy;

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= NORMAL;
            counter <= '0;
        end else if (advance) begin
            state   <= state_next;
            counter <= counter_next;
        end
    end

    assign mem_stall = (state != NORMAL) || (state_next != NORMAL);

    cache_control #(
        .OFFSET_WIDTH (OFFSET_WIDTH)
    ) i_cache_control (
        .dc_req       (dc_req),
        .ic_offset    (ic_offset),
        .dc_offset    (dc_offset),
        .ic_hit       (ic_hit),
        .ic_valid     (ic_valid),
        .dc_hit       (dc_hit),
        .dc_dirty     (dc_dirty),
        .dc_valid     (dc_valid),
        .dc_wb_word   (dc_data),
        .state        (state),
        .counter      (counter),
        .ram_ready    (ram_rsp.ready),
        .ic_cmd       (ic_cmd),
        .dc_cmd       (dc_cmd),
        .ic_word_sel  (ic_word_sel),
        .dc_word_sel  (dc_word_sel),
        .ram_addr_sel (ram_addr_sel),
        .ram_req      (ctrl_ram_req),
        .state_next   (state_next),
        .counter_next (counter_next)
    );

    cache_2ways #(
        .OFFSET_WIDTH (OFFSET_WIDTH),
        .INDEX_WIDTH  (INDEX_WIDTH)
    ) ic (
        .clk       (clk),
        .rst       (rst),
        .cmd       (ic_cmd),
        .tag_in    (ic_tag),
        .index     (ic_index),
        .word_sel  (ic_word_sel),
        .data_in   (ic_data_in),
        .hit       (ic_hit),
        .dirty     (),
        .valid_out (ic_valid),
        .tag_out   (),
        .data_out  (ic_data)
    );

    cache_2ways #(
        .OFFSET_WIDTH (OFFSET_WIDTH),
        .INDEX_WIDTH  (INDEX_WIDTH)
    ) dc (
        .clk       (clk),
        .rst       (rst),
        .cmd       (dc_cmd),
        .tag_in    (dc_tag),
        .index     (dc_index),
        .word_sel  (dc_word_sel),
        .data_in   (dc_data_in),
        .hit       (dc_hit),
        .dirty     (dc_dirty),
        .valid_out (dc_valid),
        .tag_out   (dc_tag_out),
        .data_out  (dc_data)
    );

endmodule

// ==== dv/tb_cache_manage_unit.sv ====
`timescale 1ns/1ps

module tb_cache_manage_unit
    import cache_pkg::*;
();

    localparam int N_ROWS         = 19;
    localparam int TIMEOUT_CYCLES = N_ROWS * 2 * 8 * 4 + 100;

    // Row kinds and what a row expects beyond its data
    localparam int K_FETCH  = 0;
    localparam int K_LOAD   = 1;
    localparam int K_STORE  = 2;
    localparam int K_DUAL   = 3;
    localparam int E_ANY    = 0;
    localparam int E_HIT    = 1;
    localparam int E_NO_RAM = 2;
    localparam int E_MISS   = 3;

    logic        clk = 1'b0;
    logic        rst;
    logic [29:0] ic_addr;
    dc_req_t     dc_req;
    logic [31:0] ic_data;
    logic [31:0] dc_data;
    logic        mem_stall;
    ram_req_t    ram_req;
    ram_rsp_t    ram_rsp = '0;

    logic [31:0] ram_mem [4096];
    logic [31:0] ref_mem [4096];
    logic        ram_busy = 1'b0;
    int          ram_wait = 0;
    int          ram_reads = 0;
    int          ram_writes = 0;
    int          cycles = 0;
    int          word_errors = 0;
    int          req_errors = 0;
    int          stall_errors = 0;
    int          timeout_errors = 0;

    // Stimulus table, for K_DUAL the data column holds the fetch address
    string       row_name   [N_ROWS];
    int          row_kind   [N_ROWS];
    logic [29:0] row_addr   [N_ROWS];
    logic [31:0] row_data   [N_ROWS];
    logic [3:0]  row_be     [N_ROWS];
    int          row_expect [N_ROWS];
    int          row_count = 0;

    cache_manage_unit i_cache_manage_unit (
        .clk       (clk),
        .rst       (rst),
        .ic_addr   (ic_addr),
        .dc_req    (dc_req),
        .ic_data   (ic_data),
        .dc_data   (dc_data),
        .mem_stall (mem_stall),
        .ram_req   (ram_req),
        .ram_rsp   (ram_rsp)
    );

    always #4 clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // RAM model, one word per ready strobe after 1 to 3 cycles
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        void'($urandom(54487));
        forever begin
            @(posedge clk);
            ram_rsp.ready <= 1'b0;
            if (ram_rsp.ready) begin
                // DUT moves to its next word at this edge
                ram_busy <= 1'b0;
            end else if (ram_req.en) begin
                if (!ram_busy) begin
                    ram_busy <= 1'b1;
                    ram_wait <= int'($urandom % 3);
                end else if (ram_wait == 0) begin
                    ram_rsp.ready <= 1'b1;
                    if (ram_req.write) begin
                        ram_mem[ram_req.addr[11:0]] <= ram_req.wdata;
                        ram_writes <= ram_writes + 1;
                    end else begin
                        ram_rsp.rdata <= ram_mem[ram_req.addr[11:0]];
                        ram_reads <= ram_reads + 1;
                    end
                end else begin
                    ram_wait <= ram_wait - 1;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: table not finished after %0d cycles", cycles);
            timeout_errors++;
            finish_run();
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] fill_word(input logic [11:0] a);
        return {a, 4'h6, ~a, 4'h9};
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0]  be);
        logic [31:0] result;
        result = old_word;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                result[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return result;
    endfunction

    task automatic add_row(input string name, input int kind, input logic [29:0] addr,
                           input logic [31:0] data, input logic [3:0] be, input int expect_kind);
        row_name[row_count]   = name;
        row_kind[row_count]   = kind;
        row_addr[row_count]   = addr;
        row_data[row_count]   = data;
        row_be[row_count]     = be;
        row_expect[row_count] = expect_kind;
        row_count++;
    endtask

    task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            word_errors++;
            $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    // Address and data only count while the expected request is active
    task automatic check_ram_req(input string name, input ram_req_t exp, input ram_req_t act);
        logic mismatch;
        mismatch = (act.en !== exp.en) || (act.write !== exp.write);
        if (exp.en && (act.addr !== exp.addr)) begin
            mismatch = 1'b1;
        end
        if (exp.write && (act.wdata !== exp.wdata)) begin
            mismatch = 1'b1;
        end
        if (mismatch) begin
            req_errors++;
            $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic apply_row(input int i);
        case (row_kind[i])
            K_FETCH: begin
                ic_addr <= row_addr[i];
                dc_req  <= '0;
            end
            K_STORE: begin
                dc_req <= '{read: 1'b0, write: 1'b1, byte_en: row_be[i],
                            addr: row_addr[i], wdata: row_data[i]};
            end
            default: begin
                if (row_kind[i] == K_DUAL) begin
                    ic_addr <= row_data[i][29:0];
                end
                dc_req <= '{read: 1'b1, write: 1'b0, byte_en: 4'hf,
                            addr: row_addr[i], wdata: 32'h0};
            end
        endcase
    endtask

    task automatic check_row(input int i, input int stalls, input int reads0, input int writes0);
        logic [11:0] a;
        logic [11:0] f;
        a = row_addr[i][11:0];
        f = row_data[i][11:0];
        case (row_kind[i])
            K_FETCH: check_word(row_name[i], ref_mem[a], ic_data);
            K_LOAD:  check_word(row_name[i], ref_mem[a], dc_data);
            K_STORE: ref_mem[a] = merge_bytes(ref_mem[a], row_data[i], row_be[i]);
            default: begin
                check_word({row_name[i], " fetch"}, ref_mem[f], ic_data);
                check_word({row_name[i], " load"}, ref_mem[a], dc_data);
            end
        endcase
        if ((row_expect[i] == E_MISS) && (stalls == 0)) begin
            stall_errors++;
            $display("%s: cold access returned without raising mem_stall", row_name[i]);
        end
        if (row_expect[i] == E_HIT) begin
            check_word({row_name[i], " stall cycles"}, 32'd0, stalls);
            check_ram_req({row_name[i], " ram bus"}, '0, ram_req);
        end
        if ((row_expect[i] == E_HIT) || (row_expect[i] == E_NO_RAM)) begin
            check_word({row_name[i], " ram reads"}, reads0, ram_reads);
            check_word({row_name[i], " ram writes"}, writes0, ram_writes);
        end
    endtask

    task automatic finish_run();
        $display("Errors: %0d data, %0d ram bus, %0d stall, %0d timeout",
                 word_errors, req_errors, stall_errors, timeout_errors);
        if (word_errors + req_errors + stall_errors + timeout_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        int stalls;
        int reads0;
        int writes0;

        for (int k = 0; k < 4096; k++) begin
            ram_mem[k] = fill_word(12'(k));
            ref_mem[k] = fill_word(12'(k));
        end

        add_row("fetch_cold_a",   K_FETCH, 30'h010, 32'h0,        4'h0, E_MISS);
        add_row("fetch_same_a",   K_FETCH, 30'h013, 32'h0,        4'h0, E_HIT);
        add_row("fetch_cold_b",   K_FETCH, 30'h108, 32'h0,        4'h0, E_MISS);
        add_row("fetch_same_b",   K_FETCH, 30'h10f, 32'h0,        4'h0, E_HIT);
        add_row("load_cold",      K_LOAD,  30'h080, 32'h0,        4'h0, E_MISS);
        add_row("load_hit",       K_LOAD,  30'h085, 32'h0,        4'h0, E_HIT);
        add_row("store_low_half", K_STORE, 30'h082, 32'hdeadbeef, 4'h3, E_HIT);
        add_row("load_merged",    K_LOAD,  30'h082, 32'h0,        4'h0, E_HIT);
        add_row("store_miss",     K_STORE, 30'h0c1, 32'h12345678, 4'hc, E_MISS);
        add_row("load_merged_b",  K_LOAD,  30'h0c1, 32'h0,        4'h0, E_HIT);
        // Three blocks in set 8 push out both dirty ways
        add_row("evict_store_a",  K_STORE, 30'h040, 32'ha5a5a5a5, 4'hf, E_ANY);
        add_row("evict_store_b",  K_STORE, 30'h247, 32'h0badf00d, 4'h5, E_ANY);
        add_row("evict_load_c",   K_LOAD,  30'h443, 32'h0,        4'h0, E_ANY);
        add_row("evict_reload_a", K_LOAD,  30'h040, 32'h0,        4'h0, E_ANY);
        // Fetch after store is served from the data cache
        add_row("copy_store",     K_STORE, 30'h300, 32'hcafef00d, 4'hf, E_ANY);
        add_row("copy_fetch",     K_FETCH, 30'h300, 32'h0,        4'h0, E_NO_RAM);
        add_row("copy_fetch_hit", K_FETCH, 30'h301, 32'h0,        4'h0, E_HIT);
        add_row("dual_miss",      K_DUAL,  30'h5a0, 32'h000006c8, 4'h0, E_MISS);
        add_row("dual_hit",       K_DUAL,  30'h5a7, 32'h000006cf, 4'h0, E_HIT);

        rst     = 1'b1;
        ic_addr = row_addr[0];
        dc_req  = '0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;

        @(negedge clk);
        check_ram_req("ram idle after reset", '0, ram_req);

        for (int i = 0; i < N_ROWS; i++) begin
            @(posedge clk);
            apply_row(i);
            reads0  = ram_reads;
            writes0 = ram_writes;
            stalls  = 0;
            @(negedge clk);
            while (mem_stall) begin
                stalls++;
                @(negedge clk);
            end
            check_row(i, stalls, reads0, writes0);
        end

        // Both evicted blocks of set 8 went back to RAM
        for (int k = 0; k < 8; k++) begin
            check_word("writeback block a", ref_mem['h040 + k], ram_mem['h040 + k]);
            check_word("writeback block b", ref_mem['h240 + k], ram_mem['h240 + k]);
        end

        finish_run();
    end

endmodule

// ==== verilog.f ====
hw/cache_pkg.sv
hw/cache_2ways.sv
hw/cache_control.sv
hw/cache_manage_unit.sv
dv/tb_cache_manage_unit.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the cache testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
    -f verilog.f \
    --top-module tb_cache_manage_unit \
    -o tb_sim

./obj_dir/tb_sim | tee sim.log

if grep -q "Testbench failed" sim.log; then
    echo "Simulation reported errors, see sim.log"
    exit 1
fi

echo "Simulation clean, see sim.log"
exit 0
